// ==== arithEncoder.f ====
+incdir+verif
design/arithPkg.sv
design/symbolModel.sv
design/intervalDivider.sv
design/intervalCoder.sv
design/bitPacker.sv
design/arithEncoder.sv
verif/arithEncoderTb.sv

// ==== run.sh ====
#!/bin/sh
# compiles the encoder testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module arithEncoderTb -f arithEncoder.f -o simEncoder

# a failing run may end with a nonzero status, the log decides the result
./obj_dir/simEncoder > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

// ==== verif/encoderModel.svh ====
// reference encoder with interval update, renormalization, termination and word packing
`ifndef ENCODER_MODEL_SVH
`define ENCODER_MODEL_SVH

localparam int MAX_SYMBOLS = 64;
localparam int MAX_BITS    = 1024;
localparam int MAX_WORDS   = MAX_BITS / WORD_BITS;

int                   msgSymbols [MAX_SYMBOLS];
int                   msgLength;
bit                   refBits [MAX_BITS];     // expected code bits in output order
int                   refBitCount;
logic [WORD_BITS-1:0] expWords [MAX_WORDS];
int                   expBytes [MAX_WORDS];
int                   expCount;

// one code bit, then the pending bits with the opposite value
function automatic void emitBits(input bit value, input int pending);
    refBits[refBitCount] = value;
    refBitCount++;
    for (int i = 0; i < pending; i++) begin
        refBits[refBitCount] = !value;
        refBitCount++;
    end
endfunction

function automatic void encodeMessage();
    int low;
    int high;       // exclusive upper bound
    int width;
    int pending;
    int sym;
    bit scaling;
    low         = 0;
    high        = int'(WHOLE);
    pending     = 0;
    refBitCount = 0;
    for (int i = 0; i < msgLength; i++) begin
        sym   = msgSymbols[i];
        width = high - low;
        high  = low + width * int'(CUM_FREQ[sym + 1]) / int'(TOTAL_FREQ);
        low   = low + width * int'(CUM_FREQ[sym]) / int'(TOTAL_FREQ);
        scaling = 1'b1;
        while (scaling) begin
            if (high <= int'(HALF)) begin
                emitBits(1'b0, pending);
                pending = 0;
                low     = 2 * low;
                high    = 2 * high;
            end else if (low >= int'(HALF)) begin
                emitBits(1'b1, pending);
                pending = 0;
                low     = 2 * (low - int'(HALF));
                high    = 2 * (high - int'(HALF));
            end else if (low >= int'(QUARTER) && high <= int'(THREE_QUARTERS)) begin
                pending++;                                  // straddles the middle
                low  = 2 * (low - int'(QUARTER));
                high = 2 * (high - int'(QUARTER));
            end else begin
                scaling = 1'b0;
            end
        end
    end
    // termination names the quarter that the final interval covers
    pending++;
    emitBits(low > int'(QUARTER), pending);
endfunction

// LSB-first words, the last one may be partial with zero fill
function automatic void packWords();
    int used;
    expCount = 0;
    for (int base = 0; base < refBitCount; base += WORD_BITS) begin
        expWords[expCount] = '0;
        used = 0;
        for (int k = 0; k < WORD_BITS; k++) begin
            if (base + k < refBitCount) begin
                expWords[expCount][k] = refBits[base + k];
                used++;
            end
        end
        expBytes[expCount] = (used + 7) / 8;    // bytes holding code bits
        expCount++;
    end
endfunction

`endif

// ==== verif/arithEncoderTb.sv ====
// testbench of the arithmetic encoder, host handshakes, reference model and checking assertions
`timescale 1ns/1ps
`default_nettype none

module arithEncoderTb;
    import arithPkg::*;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int MSG_SYMBOLS    = 40;     // end-of-message symbol included

    logic                 clk = 1'b0;
    logic                 rstn;
    logic                 start;
    symbol_t              symbolIn;
    logic                 symbolProvided;
    logic                 readSuccess;
    logic                 idle;
    logic                 symbolRequest;
    logic                 resultReady;
    logic [2:0]           validOutputBytes;
    logic [WORD_BITS-1:0] out;

    logic   msgActive;      // from the start edge until idle is seen again
    logic   resetCheck;
    int     wordIdx;        // words the host has read in this message
    int     maxDelay;       // longest host response delay, 0 answers at once
    integer seed;

    `include "encoderModel.svh"

    arithEncoder DUT (
        .clk              (clk),
        .rstn             (rstn),
        .start            (start),
        .symbolIn         (symbolIn),
        .symbolProvided   (symbolProvided),
        .readSuccess      (readSuccess),
        .idle             (idle),
        .symbolRequest    (symbolRequest),
        .resultReady      (resultReady),
        .validOutputBytes (validOutputBytes),
        .out              (out)
    );

    always #4 clk = ~clk;

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic string mismatch(input string name, input longint got,
                                       input longint expected);
        return $sformatf("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h",
                         $time, name, got, expected);
    endfunction

    function automatic logic probe(input string name);
        if (name == "idle") begin
            return idle;
        end else if (name == "symbolRequest") begin
            return symbolRequest;
        end else begin
            return resultReady;
        end
    endfunction

    task automatic waitSignal(input string name, input logic level);
        int cycles;
        cycles = 0;
        while (probe(name) !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stopOnError($sformatf("timeout at %0t ns, %s did not become %0b in %0d cycles",
                                      $time, name, level, TIMEOUT_CYCLES));
            end
        end
    endtask

    task automatic hostDelay();
        int cycles;
        cycles = $unsigned($random(seed)) % (maxDelay + 1);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic feedSymbols();
        start    <= 1'b1;                         // first symbol travels with start
        symbolIn <= symbol_t'(msgSymbols[0]);
        @(posedge clk);
        start     <= 1'b0;
        msgActive <= 1'b1;
        for (int i = 1; i < msgLength; i++) begin
            waitSignal("symbolRequest", 1'b1);
            hostDelay();
            symbolIn       <= symbol_t'(msgSymbols[i]);
            symbolProvided <= 1'b1;
            waitSignal("symbolRequest", 1'b0);
            hostDelay();
            symbolProvided <= 1'b0;
        end
    endtask

    task automatic readWords();
        for (int w = 0; w < expCount; w++) begin
            waitSignal("resultReady", 1'b1);
            hostDelay();
            readSuccess <= 1'b1;
            waitSignal("resultReady", 1'b0);
            hostDelay();
            readSuccess <= 1'b0;
            wordIdx     <= w + 1;
        end
    endtask

    task automatic runMessage();
        encodeMessage();
        packWords();
        wordIdx <= 0;
        fork
            feedSymbols();
            readWords();
        join
        waitSignal("idle", 1'b1);
        msgActive <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        rstn           = 1'b0;
        start          = 1'b0;
        symbolIn       = '0;
        symbolProvided = 1'b0;
        readSuccess    = 1'b0;
        msgActive      = 1'b0;
        resetCheck     = 1'b0;
        wordIdx        = 0;
        maxDelay       = 0;
        seed           = 52;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        resetCheck <= 1'b1;
        @(posedge clk);
        resetCheck <= 1'b0;

        // end-of-message symbol alone
        msgLength     = 1;
        msgSymbols[0] = int'(EOF_SYMBOL);
        runMessage();

        // random data symbols closed by the end-of-message symbol
        msgLength = MSG_SYMBOLS;
        for (int i = 0; i < MSG_SYMBOLS - 1; i++) begin
            msgSymbols[i] = $unsigned($random(seed)) % (NUM_SYMBOLS - 1);
        end
        msgSymbols[MSG_SYMBOLS - 1] = int'(EOF_SYMBOL);
        runMessage();

        // same message, slow host on both handshakes
        maxDelay = 6;
        runMessage();

        $display("=== PASS ===");
        $finish;
    end

    resetIdle: assert property (@(posedge clk) disable iff (!rstn) resetCheck |-> idle)
        else stopOnError(mismatch("idle", $sampled(idle), 1));

    quietReady: assert property (@(posedge clk) disable iff (!rstn) !msgActive |-> !resultReady)
        else stopOnError(mismatch("resultReady", $sampled(resultReady), 0));

    quietRequest: assert property (@(posedge clk) disable iff (!rstn)
        !msgActive |-> !symbolRequest)
        else stopOnError(mismatch("symbolRequest", $sampled(symbolRequest), 0));

    startLeavesIdle: assert property (@(posedge clk) disable iff (!rstn) start |=> !idle)
        else stopOnError(mismatch("idle", $sampled(idle), 0));

    // a word beyond the model's list shows up as an index past expCount
    wordCount: assert property (@(posedge clk) disable iff (!rstn)
        resultReady |-> (wordIdx < expCount))
        else stopOnError(mismatch("word index", $sampled(wordIdx), expCount - 1));

    wordValue: assert property (@(posedge clk) disable iff (!rstn)
        resultReady |-> (out == expWords[wordIdx]))
        else stopOnError(mismatch("out", $sampled(out), expWords[$sampled(wordIdx)]));

    wordBytes: assert property (@(posedge clk) disable iff (!rstn)
        resultReady |-> (int'(validOutputBytes) == expBytes[wordIdx]))
        else stopOnError(mismatch("validOutputBytes", $sampled(validOutputBytes),
                                  expBytes[$sampled(wordIdx)]));

    readHold: assert property (@(posedge clk) disable iff (!rstn)
        (resultReady && !readSuccess) |=> resultReady)
        else stopOnError(mismatch("resultReady", $sampled(resultReady), 1));

    requestHold: assert property (@(posedge clk) disable iff (!rstn)
        (symbolRequest && !symbolProvided) |=> symbolRequest)
        else stopOnError(mismatch("symbolRequest", $sampled(symbolRequest), 1));

    // idle only after the host has taken every word
    finalIdle: assert property (@(posedge clk) disable iff (!rstn)
        (msgActive && idle) |-> (wordIdx == expCount))
        else stopOnError(mismatch("words read at idle", $sampled(wordIdx), expCount));

endmodule

`default_nettype wire

// ==== design/arithEncoder.sv ====
// top level of the arithmetic encoder, symbol model, interval coder, divider and packer
`timescale 1ns/1ps
`default_nettype none

module arithEncoder (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             start,
    input  wire arithPkg::symbol_t          symbolIn,
    input  wire                             symbolProvided,
    input  wire                             readSuccess,
    output logic                            idle,
    output logic                            symbolRequest,
    output logic                            resultReady,
    output logic [2:0]                      validOutputBytes,
    output logic [arithPkg::WORD_BITS-1:0]  out
);
    import arithPkg::*;

    symbol_t   curSymbol;
    cumRange_t range;
    logic      divStart;
    product_t  dividend;
    logic      divDone;
    interval_t quotient;
    bitOut_t   bitOut;
    logic      bitReady;

    symbolModel decodeStage (
        .symbol (curSymbol),
        .range  (range)
    );

    intervalDivider divider (
        .clk      (clk),
        .rstn     (rstn),
        .divStart (divStart),
        .dividend (dividend),
        .divDone  (divDone),
        .quotient (quotient)
    );

    intervalCoder coder (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .symbolIn       (symbolIn),
        .symbolProvided (symbolProvided),
        .symbolRequest  (symbolRequest),
        .idle           (idle),
        .range          (range),
        .curSymbol      (curSymbol),
        .divStart       (divStart),
        .dividend       (dividend),
        .divDone        (divDone),
        .quotient       (quotient),
        .bitOut         (bitOut),
        .bitReady       (bitReady)
    );

    bitPacker packer (
        .clk              (clk),
        .rstn             (rstn),
        .bitIn            (bitOut),
        .bitReady         (bitReady),
        .readSuccess      (readSuccess),
        .resultReady      (resultReady),
        .validOutputBytes (validOutputBytes),
        .out              (out)
    );

endmodule

`default_nettype wire

// ==== design/bitPacker.sv ====
// result stage, LSB-first packing of code bits into words with the host read handshake
`timescale 1ns/1ps
`default_nettype none

module bitPacker (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire arithPkg::bitOut_t          bitIn,
    output logic                            bitReady,
    input  wire                             readSuccess,
    output logic                            resultReady,
    output logic [2:0]                      validOutputBytes,
    output logic [arithPkg::WORD_BITS-1:0]  out
);
    import arithPkg::*;

    typedef enum logic [1:0] {
        COLLECT,
        PRESENT,
        RELEASE
    } packState_e;

    packState_e                   packState;
    logic [$clog2(WORD_BITS)-1:0] bitCount;   // next free bit of the word

    assign bitReady = (packState == COLLECT);  // back-pressure toward the coder

    always_ff @(posedge clk) begin
        if (!rstn) begin
            packState        <= COLLECT;
            bitCount         <= '0;
            resultReady      <= 1'b0;
            validOutputBytes <= '0;
            out              <= '0;
        end else begin
            unique case (packState)
                COLLECT: if (bitIn.valid) begin
                    out[bitCount] <= bitIn.value;
                    if (bitIn.last || bitCount == WORD_BITS - 1) begin
                        // bytes touched so far, 4 on a full word
                        validOutputBytes <= 3'(bitCount >> 3) + 3'd1;
                        resultReady      <= 1'b1;
                        bitCount         <= '0;
                        packState        <= PRESENT;
                    end else begin
                        bitCount <= bitCount + 1'b1;
                    end
                end
                PRESENT: if (readSuccess) begin
                    out         <= '0;               // unused bits of the next word stay 0
                    resultReady <= 1'b0;
                    packState   <= RELEASE;
                end
                RELEASE: if (!readSuccess) packState <= COLLECT;
                default: packState <= COLLECT;
            endcase
        end
    end

    // the host sees a steady word until it acknowledges the read
    assert property (@(posedge clk) disable iff (!rstn)
        (resultReady && !readSuccess) |=> (resultReady && $stable(out)))
        else $error("bitPacker: word withdrawn before readSuccess");

endmodule

`default_nettype wire

// ==== design/intervalCoder.sv ====
// execute stage, encoder FSM with interval update, renormalization and pending bits
`timescale 1ns/1ps
`default_nettype none

module intervalCoder (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       start,
    input  wire arithPkg::symbol_t    symbolIn,
    input  wire                       symbolProvided,
    output logic                      symbolRequest,
    output logic                      idle,
    input  wire arithPkg::cumRange_t  range,
    output arithPkg::symbol_t         curSymbol,
    output logic                      divStart,
    output arithPkg::product_t        dividend,
    input  wire                       divDone,
    input  wire arithPkg::interval_t  quotient,
    output arithPkg::bitOut_t         bitOut,
    input  wire                       bitReady
);
    import arithPkg::*;

    coderState_e             state;
    interval_t               low;
    interval_t               high;        // exclusive upper bound
    interval_t               width;
    product_t                prodLow;     // waits while the upper bound is divided
    logic [PENDING_BITS-1:0] pending;
    logic                    pendValue;
    logic                    finishing;   // termination bits are on their way
    logic                    lowerHalf;
    logic                    upperHalf;
    logic                    middle;

    assign lowerHalf = (high <= HALF);
    assign upperHalf = (low >= HALF);
    assign middle    = (low >= QUARTER) && (high <= THREE_QUARTERS);

    // not idle until the packer has handed the final word to the host
    assign idle = (state == IDLE) && bitReady;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= IDLE;
            symbolRequest <= 1'b0;
            divStart      <= 1'b0;
            bitOut        <= '0;
            curSymbol     <= '0;
            pending       <= '0;
            finishing     <= 1'b0;
        end else begin
            divStart <= 1'b0;
            unique case (state)
                IDLE: if (start && bitReady) begin
                    curSymbol <= symbolIn;
                    pending   <= '0;
                    finishing <= 1'b0;
                    state     <= LOAD;
                end
                LOAD: state <= MULTIPLY;
                MULTIPLY: begin
                    divStart <= 1'b1;                   // upper bound first
                    state    <= DIV_HIGH;
                end
                DIV_HIGH: if (divDone) begin
                    divStart <= 1'b1;
                    state    <= DIV_LOW;
                end
                DIV_LOW: if (divDone) state <= RENORM;
                RENORM: begin
                    if (lowerHalf || upperHalf) begin
                        bitOut <= '{valid: 1'b1, value: !lowerHalf, last: 1'b0};
                        state  <= EMIT_PENDING;
                    end else if (middle) begin
                        pending <= pending + 1'b1;
                    end else if (range.isEof) begin
                        state <= TERMINATE;
                    end else begin
                        symbolRequest <= 1'b1;
                        state         <= REQUEST;
                    end
                end
                EMIT_PENDING: if (bitReady) begin   // stall here while the packer is full
                    if (pending != 0) begin
                        bitOut.value <= pendValue;
                        bitOut.last  <= finishing && (pending == 1);
                        pending      <= pending - 1'b1;
                    end else begin
                        bitOut <= '0;
                        state  <= finishing ? IDLE : RENORM;
                    end
                end
                TERMINATE: begin
                    finishing <= 1'b1;
                    pending   <= pending + 1'b1;
                    bitOut    <= '{valid: 1'b1, value: (low > QUARTER), last: 1'b0};
                    state     <= EMIT_PENDING;
                end
                REQUEST: if (symbolProvided) begin
                    curSymbol     <= symbolIn;
                    symbolRequest <= 1'b0;
                    state         <= WAIT_RELEASE;
                end
                WAIT_RELEASE: if (!symbolProvided) state <= LOAD;
                default: state <= IDLE;
            endcase
        end
    end

    // interval datapath, follows the FSM state
    always_ff @(posedge clk) begin
        unique case (state)
            IDLE: begin
                low  <= '0;
                high <= WHOLE;
            end
            LOAD: width <= high - low;
            MULTIPLY: begin
                dividend <= product_t'(width) * product_t'(range.high);
                prodLow  <= product_t'(width) * product_t'(range.low);
            end
            DIV_HIGH: if (divDone) begin
                high     <= low + quotient;
                dividend <= prodLow;
            end
            DIV_LOW: if (divDone) low <= low + quotient;
            RENORM: begin
                if (lowerHalf) begin
                    low       <= low << 1;
                    high      <= high << 1;
                    pendValue <= 1'b1;              // pending bits follow as 1s
                end else if (upperHalf) begin
                    low       <= (low - HALF) << 1;
                    high      <= (high - HALF) << 1;
                    pendValue <= 1'b0;
                end else if (middle) begin
                    low  <= (low - QUARTER) << 1;
                    high <= (high - QUARTER) << 1;
                end
            end
            TERMINATE: pendValue <= (low <= QUARTER);
            default: ;
        endcase
    end

    // holds across the divider results and every rescale step
    assert property (@(posedge clk) disable iff (!rstn)
        (state inside {RENORM, TERMINATE}) |-> (low < high))
        else $error("intervalCoder: interval collapsed, low %0d high %0d", low, high);

endmodule

`default_nettype wire

// ==== design/intervalDivider.sv ====
// sequential restoring divider of a width-frequency product by the total frequency
`timescale 1ns/1ps
`default_nettype none

module intervalDivider (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      divStart,
    input  wire arithPkg::product_t  dividend,
    output logic                     divDone,
    output arithPkg::interval_t      quotient
);
    import arithPkg::*;

    freq_t                 partial;   // running remainder, stays below TOTAL_FREQ
    logic [FREQ_BITS:0]    trial;
    logic [COUNT_BITS-1:0] count;
    logic                  busy;

    // next dividend bit leaves the top of the quotient register
    assign trial = {partial, quotient[PRECISION-1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            count   <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                busy  <= 1'b1;
                count <= COUNT_BITS'(PRECISION);   // one quotient bit per cycle
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == 1) begin
                    busy    <= 1'b0;
                    divDone <= 1'b1;
                end
            end
        end
    end

    // quotient bits shift in at the bottom while dividend bits shift out at the top
    always_ff @(posedge clk) begin
        if (divStart) begin
            partial  <= dividend[PRODUCT_BITS-1 -: FREQ_BITS];
            quotient <= dividend[PRECISION-1:0];
        end else if (busy) begin
            if (trial >= TOTAL_FREQ) begin
                partial  <= freq_t'(trial - TOTAL_FREQ);
                quotient <= {quotient[PRECISION-2:0], 1'b1};
            end else begin
                partial  <= freq_t'(trial);
                quotient <= {quotient[PRECISION-2:0], 1'b0};
            end
        end
    end

    // the coder keeps only one division in flight
    assert property (@(posedge clk) disable iff (!rstn) divStart |-> !busy)
        else $error("intervalDivider: divStart while a division is running");

endmodule

`default_nettype wire

// ==== design/symbolModel.sv ====
// decode stage, fixed probability model lookup of one symbol
`timescale 1ns/1ps
`default_nettype none

module symbolModel (
    input  wire arithPkg::symbol_t   symbol,
    output arithPkg::cumRange_t      range
);
    import arithPkg::*;

    symbol_t nextSymbol;

    assign nextSymbol = symbol + 1'b1;    // upper bound sits in the following slot

    always_comb begin
        range.low   = CUM_FREQ[symbol];
        range.high  = CUM_FREQ[nextSymbol];
        range.isEof = (symbol == EOF_SYMBOL);
    end

    // a symbol from the host that the model does not know would corrupt the interval
    always_comb begin
        if (!$isunknown(symbol)) begin
            assert (int'(symbol) < NUM_SYMBOLS)
                else $error("symbolModel: symbol %0d outside the model", symbol);
        end
    end

endmodule

`default_nettype wire

// ==== design/arithPkg.sv ====
// precision constants, probability model table, datapath types and coder FSM states
`default_nettype none

package arithPkg;

    localparam int PRECISION    = 14;
    localparam int FREQ_BITS    = 11;
    localparam int PRODUCT_BITS = PRECISION + FREQ_BITS;
    localparam int NUM_SYMBOLS  = 17;
    localparam int SYMBOL_BITS  = $clog2(NUM_SYMBOLS);
    localparam int WORD_BITS    = 32;
    localparam int COUNT_BITS   = $clog2(PRECISION + 1);   // divider step counter
    localparam int PENDING_BITS = 8;

    typedef logic [SYMBOL_BITS-1:0]  symbol_t;
    typedef logic [PRECISION-1:0]    interval_t;
    typedef logic [FREQ_BITS-1:0]    freq_t;
    typedef logic [PRODUCT_BITS-1:0] product_t;

    // interval bounds, the full range is [0, WHOLE)
    localparam interval_t WHOLE          = interval_t'(1 << (PRECISION - 1));
    localparam interval_t HALF           = interval_t'(1 << (PRECISION - 2));
    localparam interval_t QUARTER        = interval_t'(1 << (PRECISION - 3));
    localparam interval_t THREE_QUARTERS = interval_t'(3 << (PRECISION - 3));

    localparam symbol_t EOF_SYMBOL = symbol_t'(NUM_SYMBOLS - 1);
    localparam freq_t   TOTAL_FREQ = freq_t'(1024);          // kept below QUARTER

    // symbol k owns [CUM_FREQ[k], CUM_FREQ[k+1]), the last slot is end of message
    localparam freq_t CUM_FREQ [0:NUM_SYMBOLS] = '{
        11'd0,    11'd200,  11'd350,  11'd470,  11'd570,  11'd650,
        11'd720,  11'd780,  11'd830,  11'd870,  11'd900,  11'd925,
        11'd945,  11'd965,  11'd985,  11'd1000, 11'd1014, 11'd1024
    };

    typedef struct packed {
        freq_t low;      // cumulative count below the symbol
        freq_t high;     // cumulative count up to and including the symbol
        logic  isEof;
    } cumRange_t;

    typedef struct packed {
        logic valid;
        logic value;
        logic last;      // final code bit of the message
    } bitOut_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD,
        MULTIPLY,
        DIV_HIGH,
        DIV_LOW,
        RENORM,
        EMIT_PENDING,
        TERMINATE,
        REQUEST,
        WAIT_RELEASE
    } coderState_e;

endpackage

`default_nettype wire
